//--- data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem
	import mem_pkg::*;
(
	input  logic         clk,
	input  logic         write_en,   // already gated by alignment
	input  logic         zero_ext,   // lbu / lhu
	input  dmem_addr_t   addr,       // byte address of lane 0
	input  access_size_t size,
	input  word_t        wdata,
	output word_t        rdata
);

	// byte organised storage, no reset
	byte_t mem [DMEM_BYTES];

	// byte address of each lane, wraps inside the 17 bit space
	dmem_addr_t lane_addr [BYTE_LANES];

	// raw bytes seen at the lanes
	byte_t rd_lane [BYTE_LANES];

	// per lane write strobe
	logic [BYTE_LANES-1:0] lane_we;

	// assembled halfword, for lh / lhu
	logic [2*BYTE_W-1:0] rd_half;

	// lanes touched by an access of the given size
	function automatic logic [BYTE_LANES-1:0] lane_mask(input access_size_t sz);
		logic [BYTE_LANES-1:0] m;
		case (sz)
			size_byte: m = 4'b0001;
			size_half: m = 4'b0011;
			size_word: m = 4'b1111;
			default:   m = 4'b0000;  // bad size touches nothing
		endcase
		return m;
	endfunction

	initial begin
		// preload, remaining bytes stay x
		$readmemh(DMEM_INIT_FILE, mem);
	end

	genvar g;
	generate
		for (g = 0; g < BYTE_LANES; g++) begin : g_lane
			// little endian, lane g sits at addr + g
			assign lane_addr[g] = addr + dmem_addr_t'(g);
			assign rd_lane[g] = mem[lane_addr[g]];
		end
	endgenerate

	assign lane_we = write_en ? lane_mask(size) : '0;

	// stores land on the edge that closes the access cycle
	always_ff @(posedge clk) begin
		for (int i = 0; i < BYTE_LANES; i++) begin
			if (lane_we[i]) begin
				mem[lane_addr[i]] <= wdata[BYTE_W*i +: BYTE_W];  // lane i of wdata
			end
		end
	end

	assign rd_half = {rd_lane[1], rd_lane[0]};

	// combinational read, extended by size
	always_comb begin
		case (size)
			size_byte: begin
				if (zero_ext) begin
					rdata = {{(XLEN-BYTE_W){1'b0}}, rd_lane[0]};              // lbu
				end else begin
					rdata = {{(XLEN-BYTE_W){rd_lane[0][BYTE_W-1]}}, rd_lane[0]};  // lb
				end
			end
			size_half: begin
				if (zero_ext) begin
					rdata = {{(XLEN-2*BYTE_W){1'b0}}, rd_half};               // lhu
				end else begin
					rdata = {{(XLEN-2*BYTE_W){rd_half[2*BYTE_W-1]}}, rd_half};  // lh
				end
			end
			size_word: begin
				// zero_ext has no meaning at full width
				rdata = {rd_lane[3], rd_lane[2], rd_lane[1], rd_lane[0]};
			end
			default: begin
				rdata = '0;  // bad size reads zero
			end
		endcase
	end

endmodule

`default_nettype wire

//--- data_mem_init.mem
// preload bytes in address order from 0x00, one hex byte per entry
// each line holds four entries, line n covers 4n .. 4n+3
12 8a 7f 80
01 fe 34 c3
9c 45 e7 2b
60 d1 0f a8
77 b6 3e 91
5a ff 00 e2
23 84 c9 6d
f0 1e 47 bb
08 99 72 de
3a a5 11 cc
6b 82 dd 40
95 27 f3 0c
4e b1 68 8f
2d e4 53 a0
c7 19 7b 86
0a fa 36 d8
81 44 ec 29
b9 63 05 9e
57 c2 1b f6
70 8d 3c e9
14 ab 66 d5
93 2f b4 48
e0 0d 7e a3
31 cf 59 96
85 42 fb 1a
6e b8 27 d4
03 97 4c ea
af 5d 18 c5
62 f9 3b 8e
25 b0 71 dc
49 e6 0b 9a
7c 13 c8 55

//--- load_store_unit.sv
`timescale 1ns/10ps
`default_nettype none

module load_store_unit
	import mem_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         mem_read,    // load this cycle
	input  logic         mem_write,   // store this cycle
	input  word_t        base,        // rs1 value
	input  word_t        store_data,  // rs2 value
	input  word_t        rdata,       // raw read from data_mem
	input  imm_t         offset,      // 12 bit, sign extended here
	input  funct3_t      funct3,
	output dmem_addr_t   addr,
	output access_size_t size,
	output logic         zero_ext,
	output logic         write_en,
	output word_t        wdata,
	output word_t        load_data,
	output logic         misaligned,  // same cycle pulse
	output logic         fault        // sticky until reset
);

	word_t offset_ext;   // sign extended offset
	word_t eff_addr;     // full 32 bit effective address
	logic access;        // either strobe high
	logic align_bad;     // size / address pair not allowed

	// address generation
	assign offset_ext = {{(XLEN-12){offset[11]}}, offset};
	assign eff_addr = base + offset_ext;

	// bits above the 17 bit map are dropped
	assign addr = eff_addr[DMEM_ADDR_BITS-1:0];

	// funct3 decode
	assign size = access_size_t'(funct3[1:0]);
	assign zero_ext = funct3[F3_ZEXT_BIT];

	// alignment check on the byte address
	always_comb begin
		case (size)
			size_byte: align_bad = 1'b0;          // any byte is fine
			size_half: align_bad = addr[0];       // must be even
			size_word: align_bad = |addr[1:0];    // multiple of four
			default:   align_bad = 1'b1;          // size_bad always refused
		endcase
	end

	assign access = mem_read | mem_write;

	// only flag when something is actually accessed
	assign misaligned = access & align_bad;

	// refused store writes nothing
	assign write_en = mem_write & ~align_bad;
	assign wdata = store_data;

	// refused load reads as zero
	assign load_data = misaligned ? '0 : rdata;

	// sticky fault, stands in for the trap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fault <= 1'b0;
		end else if (misaligned) begin
			fault <= 1'b1;  // set on first refused access, held after
		end
	end

endmodule

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

	// core data width, rv32i
	localparam int XLEN = 32;

	// one storage byte
	localparam int BYTE_W = 8;

	// byte lanes in one word
	localparam int BYTE_LANES = XLEN / BYTE_W;

	// data memory map runs 0x00000 .. 0x1ffff
	localparam int DMEM_ADDR_BITS = 17;
	localparam int DMEM_BYTES = 2 ** DMEM_ADDR_BITS;

	// hex preload image, one byte per entry
	localparam string DMEM_INIT_FILE = "data_mem_init.mem";

	// funct3[2] picks zero extension on lbu / lhu
	localparam int F3_ZEXT_BIT = 2;

	typedef logic [XLEN-1:0] word_t;           // register values, store and load data
	typedef logic [11:0] imm_t;                // raw i/s-type offset
	typedef logic [DMEM_ADDR_BITS-1:0] dmem_addr_t;
	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [2:0] funct3_t;

	// funct3[1:0] access width
	typedef enum logic [1:0] {
		size_byte = 2'b00,  // lb lbu sb
		size_half = 2'b01,  // lh lhu sh
		size_word = 2'b10,  // lw sw
		size_bad  = 2'b11   // not defined in rv32i
	} access_size_t;

endpackage

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage
	import mem_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    mem_read,
	input  logic    mem_write,
	input  word_t   base,
	input  word_t   store_data,
	input  imm_t    offset,
	input  funct3_t funct3,
	output word_t   load_data,
	output logic    misaligned,
	output logic    fault
);

	// lsu to memory
	dmem_addr_t   addr;
	access_size_t size;
	logic         zero_ext;
	logic         write_en;
	word_t        wdata;

	// memory back to lsu
	word_t        rdata;

	// address, decode, gating and fault
	load_store_unit lsu_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.base       (base),
		.store_data (store_data),
		.rdata      (rdata),
		.offset     (offset),
		.funct3     (funct3),
		.addr       (addr),
		.size       (size),
		.zero_ext   (zero_ext),
		.write_en   (write_en),
		.wdata      (wdata),
		.load_data  (load_data),
		.misaligned (misaligned),
		.fault      (fault)
	);

	// byte array, comb read, clocked write
	data_mem dmem_i (
		.clk      (clk),
		.write_en (write_en),
		.zero_ext (zero_ext),
		.addr     (addr),
		.size     (size),
		.wdata    (wdata),
		.rdata    (rdata)
	);

endmodule

`default_nettype wire

//--- mem_stage_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_assertions (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic write_en,
	input logic misaligned,
	input logic fault
);

	int assert_fails = 0;  // failures seen, summed into the tb error count

	// refused access never reaches the byte array
	write_gated: assert property (@(posedge clk) disable iff (!rst_n)
		misaligned |-> !write_en)
	else begin
		assert_fails++;
		$error("write_en high during a refused access");
	end

	// one access kind per cycle
	one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_read && mem_write))
	else begin
		assert_fails++;
		$error("mem_read and mem_write high together");
	end

	// sticky, only reset clears it
	fault_held: assert property (@(posedge clk) disable iff (!rst_n)
		!$fell(fault))
	else begin
		assert_fails++;
		$error("fault dropped outside reset");
	end

	// clean start after reset release
	fault_clear: assert property (@(posedge clk) $rose(rst_n) |-> !fault)
	else begin
		assert_fails++;
		$error("fault high right after reset");
	end

endmodule

bind load_store_unit mem_stage_assertions lsu_checks_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.mem_read   (mem_read),
	.mem_write  (mem_write),
	.write_en   (write_en),
	.misaligned (misaligned),
	.fault      (fault)
);

`default_nettype wire

//--- mem_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_tb
	import mem_pkg::*;
();

	localparam int RST_CYCLES = 16;
	localparam int MAX_CYCLES = 4000;    // well above the tests' length
	localparam int PRELOAD_BYTES = 128;  // size of the hex image
	localparam int STORE_ROUNDS = 24;
	localparam logic [31:0] SEED = 32'h0bbff594;

	// rv32i load / store funct3
	localparam funct3_t F3_B = 3'b000;
	localparam funct3_t F3_H = 3'b001;
	localparam funct3_t F3_W = 3'b010;
	localparam funct3_t F3_BU = 3'b100;
	localparam funct3_t F3_HU = 3'b101;
	localparam funct3_t F3_BAD = 3'b011;  // size field 11

	logic clk;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	word_t base;
	word_t store_data;
	imm_t offset;
	funct3_t funct3;
	word_t load_data;
	logic misaligned;
	logic fault;

	byte_t ref_mem [PRELOAD_BYTES];  // reference copy of the low bytes
	logic [31:0] rng_state;
	int check_count;
	int error_count;
	int cycle_count = 0;

	mem_stage mem_stage_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.base       (base),
		.store_data (store_data),
		.offset     (offset),
		.funct3     (funct3),
		.load_data  (load_data),
		.misaligned (misaligned),
		.fault      (fault)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	// run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// halfword odd, word not on four, or size 11
	function automatic logic is_refused(input dmem_addr_t a, input funct3_t f3);
		case (f3[1:0])
			2'b00: return 1'b0;
			2'b01: return a[0];
			2'b10: return a[1:0] != 2'b00;
			default: return 1'b1;
		endcase
	endfunction

	function automatic word_t predict_load(input dmem_addr_t a, input funct3_t f3);
		int idx;
		logic [15:0] h;
		idx = int'(a);
		if (is_refused(a, f3)) begin
			return '0;  // refused load reads zero
		end
		case (f3[1:0])
			2'b00: begin
				if (f3[2]) return {24'h0, ref_mem[idx]};
				return {{24{ref_mem[idx][7]}}, ref_mem[idx]};
			end
			2'b01: begin
				h = {ref_mem[idx+1], ref_mem[idx]};  // little endian
				if (f3[2]) return {16'h0, h};
				return {{16{h[15]}}, h};
			end
			default: return {ref_mem[idx+3], ref_mem[idx+2], ref_mem[idx+1], ref_mem[idx]};
		endcase
	endfunction

	function automatic void apply_store(input dmem_addr_t a, input funct3_t f3, input word_t d);
		int idx;
		idx = int'(a);
		if (!is_refused(a, f3)) begin
			for (int i = 0; i < (1 << f3[1:0]); i++) begin
				ref_mem[idx+i] = d[8*i +: 8];  // lane i
			end
		end
	endfunction

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("error %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("error %s: expected %b actual %b", name, expected, actual);
		end
	endtask

	// one access cycle then one idle cycle, outputs sampled mid cycle
	task automatic access(input logic wr, input dmem_addr_t a, input funct3_t f3,
			input word_t sd, input logic neg_off, output word_t ld, output logic mis);
		logic [31:0] r;
		imm_t off;
		word_t b;
		r = next_rand();
		off = {neg_off, r[10:0]};
		// junk above bit 16, low bits land on a after the add
		b = {r[31:17], 17'b0} + word_t'(a) - {{20{off[11]}}, off};
		@(posedge clk);
		mem_read <= !wr;
		mem_write <= wr;
		base <= b;
		offset <= off;
		funct3 <= f3;
		store_data <= sd;
		@(negedge clk);
		ld = load_data;
		mis = misaligned;
		@(posedge clk);  // store lands here
		mem_read <= 1'b0;
		mem_write <= 1'b0;
	endtask

	task automatic load_check(input string name, input dmem_addr_t a, input funct3_t f3);
		word_t ld;
		logic mis;
		access(1'b0, a, f3, '0, a[2], ld, mis);
		check_word(name, predict_load(a, f3), ld);
		check_flag(name, is_refused(a, f3), mis);
	endtask

	task automatic store_op(input string name, input dmem_addr_t a, input funct3_t f3,
			input word_t d, input logic neg_off);
		word_t ld;
		logic mis;
		access(1'b1, a, f3, d, neg_off, ld, mis);
		check_flag(name, is_refused(a, f3), mis);
		apply_store(a, f3, d);
	endtask

	task automatic reset_dut();
		@(posedge clk);
		rst_n <= 1'b0;
		mem_read <= 1'b0;
		mem_write <= 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("test %s finished, %0d errors", name, error_count - errs_before);
	endtask

	task automatic test_reset_lw();
		int errs;
		errs = error_count;
		@(negedge clk);
		check_flag("reset_lw", 1'b0, fault);
		check_flag("reset_lw", 1'b0, misaligned);  // idle
		for (int i = 0; i < 8; i++) begin
			load_check("reset_lw", dmem_addr_t'(i * 16 + (i % 4) * 4), F3_W);
		end
		report_test("reset_lw", errs);
	endtask

	task automatic test_sub_word();
		int errs;
		errs = error_count;
		for (int i = 0; i < 16; i++) begin
			load_check("sub_word", dmem_addr_t'(8 + i), F3_B);
			load_check("sub_word", dmem_addr_t'(8 + i), F3_BU);
		end
		for (int i = 0; i < 16; i++) begin
			load_check("sub_word", dmem_addr_t'(56 + 2 * i), F3_H);
			load_check("sub_word", dmem_addr_t'(56 + 2 * i), F3_HU);
		end
		report_test("sub_word", errs);
	endtask

	task automatic test_stores();
		int errs;
		funct3_t f3;
		dmem_addr_t a;
		logic [31:0] r;
		errs = error_count;
		for (int i = 0; i < STORE_ROUNDS; i++) begin
			r = next_rand();
			f3 = funct3_t'(i % 3);  // sb sh sw
			a = dmem_addr_t'(r[6:0]);
			if (f3 == F3_H) a[0] = 1'b0;
			if (f3 == F3_W) a[1:0] = 2'b00;
			store_op("stores", a, f3, next_rand(), i[0]);  // offset sign alternates
			load_check("stores", {a[16:2], 2'b00}, F3_W);
		end
		report_test("stores", errs);
	endtask

	task automatic test_refused();
		int errs;
		errs = error_count;
		store_op("refused", 17'h00021, F3_H, next_rand(), 1'b0);
		load_check("refused", 17'h00020, F3_W);
		store_op("refused", 17'h0002f, F3_H, next_rand(), 1'b1);
		load_check("refused", 17'h0002c, F3_W);
		store_op("refused", 17'h00042, F3_W, next_rand(), 1'b0);
		load_check("refused", 17'h00040, F3_W);
		store_op("refused", 17'h00047, F3_W, next_rand(), 1'b1);
		load_check("refused", 17'h00044, F3_W);
		store_op("refused", 17'h00050, F3_BAD, next_rand(), 1'b0);
		load_check("refused", 17'h00050, F3_W);
		store_op("refused", 17'h00058, 3'b111, next_rand(), 1'b1);
		load_check("refused", 17'h00058, F3_W);
		// refused loads read zero
		load_check("refused", 17'h00011, F3_H);
		load_check("refused", 17'h00033, F3_HU);
		load_check("refused", 17'h00006, F3_W);
		load_check("refused", 17'h00009, F3_W);
		load_check("refused", 17'h0000c, F3_BAD);
		load_check("refused", 17'h00010, 3'b111);
		@(negedge clk);
		check_flag("refused", 1'b0, misaligned);  // idle, bad funct3 still driven
		report_test("refused", errs);
	endtask

	task automatic test_fault();
		int errs;
		errs = error_count;
		reset_dut();
		@(negedge clk);
		check_flag("fault", 1'b0, fault);
		load_check("fault", 17'h00010, F3_W);
		@(negedge clk);
		check_flag("fault", 1'b0, fault);  // good access leaves it low
		load_check("fault", 17'h00013, F3_H);
		@(negedge clk);
		check_flag("fault", 1'b1, fault);  // set by the refused load
		for (int i = 0; i < 4; i++) begin
			store_op("fault", dmem_addr_t'(96 + 4 * i), F3_W, next_rand(), i[0]);
			load_check("fault", dmem_addr_t'(96 + 4 * i), F3_W);
			@(negedge clk);
			check_flag("fault", 1'b1, fault);
		end
		reset_dut();
		@(negedge clk);
		check_flag("fault", 1'b0, fault);
		report_test("fault", errs);
	endtask

	initial begin
		rng_state = SEED;
		check_count = 0;
		error_count = 0;
		rst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		base = '0;
		store_data = '0;
		offset = '0;
		funct3 = '0;
		$readmemh(DMEM_INIT_FILE, ref_mem);
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		test_reset_lw();
		test_sub_word();
		test_stores();
		test_refused();
		test_fault();
		// bound assertion failures count as errors too
		error_count += mem_stage_i.lsu_i.lsu_checks_i.assert_fails;
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- riscv_mem.f
mem_pkg.sv
data_mem.sv
load_store_unit.sv
mem_stage.sv
mem_stage_assertions.sv
mem_stage_tb.sv
